/* Makefile */
# Verilator build and run of the SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
SEED      ?= 95036
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove the $(BUILD) directory"
	@echo "variables: VERILATOR TOP SEED BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)

/* all.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/soc_pkg.sv
hdl/bus_skid_buffer.sv
hdl/bus_interconnect.sv
hdl/sram_slave.sv
hdl/led_slave.sv
hdl/status_display.sv
hdl/soc_top.sv
verification/tb_soc_top.sv

/* hdl/bus_interconnect.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module bus_interconnect (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wq_valid,
    input  bus_pkg::wr_req_t wq_data,
    output logic             wq_ready,
    input  logic             rq_valid,
    input  bus_pkg::rd_req_t rq_data,
    output logic             rq_ready,
    output logic             b_valid,
    output bus_pkg::resp_t   b_resp,
    input  logic             b_ready,
    output logic             r_valid,
    output bus_pkg::data_t   r_data,
    output bus_pkg::resp_t   r_resp,
    input  logic             r_ready,
    output logic             mem_sel,
    output logic             led_sel,
    output logic             acc_we,
    output bus_pkg::addr_t   acc_addr,
    output bus_pkg::data_t   acc_wdata,
    output bus_pkg::strb_t   acc_strb,
    input  bus_pkg::data_t   mem_rdata,
    input  bus_pkg::data_t   led_rdata,
    output logic [7:0]       write_count,
    output logic [7:0]       read_count,
    output logic [7:0]       error_count
);
    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESP} state_t;

    state_t           state;
    soc_pkg::target_t cur_tgt;
    bus_pkg::rsp_t    rsp;
    bus_pkg::addr_t   pick_addr;
    logic             pop;
    logic             done;

    function automatic soc_pkg::target_t decode(input bus_pkg::addr_t addr);
        case (addr[`SOC_ADDR_W-1 -: 4])
            `SOC_REGION_MEM: decode = soc_pkg::TGT_MEM;
            `SOC_REGION_LED: decode = soc_pkg::TGT_LED;
            default:         decode = soc_pkg::TGT_NONE;
        endcase
    endfunction

    assign wq_ready  = (state == ST_IDLE);
    assign rq_ready  = (state == ST_IDLE) && !wq_valid;   // write wins
    assign pop       = (wq_valid && wq_ready) || (rq_valid && rq_ready);
    assign pick_addr = wq_valid ? wq_data.addr : rq_data.addr;

    // latch the popped request, it drives the slaves next cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            acc_we    <= wq_valid;
            acc_addr  <= pick_addr;
            acc_wdata <= wq_data.data;
            acc_strb  <= wq_data.strb;
            cur_tgt   <= decode(pick_addr);
        end
    end

    assign mem_sel = (state == ST_ACCESS) && (cur_tgt == soc_pkg::TGT_MEM);
    assign led_sel = (state == ST_ACCESS) && (cur_tgt == soc_pkg::TGT_LED);

    // slave rdata holds until its next sel, so the response stays stable
    always_comb begin
        rsp.resp = (cur_tgt == soc_pkg::TGT_NONE) ? bus_pkg::DECERR : bus_pkg::OKAY;
        case (cur_tgt)
            soc_pkg::TGT_MEM: rsp.data = mem_rdata;
            soc_pkg::TGT_LED: rsp.data = led_rdata;
            default:          rsp.data = '0;
        endcase
    end

    assign b_valid = (state == ST_RESP) && acc_we;
    assign r_valid = (state == ST_RESP) && !acc_we;
    assign b_resp  = rsp.resp;
    assign r_resp  = rsp.resp;
    assign r_data  = rsp.data;
    assign done    = (b_valid && b_ready) || (r_valid && r_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (pop) state <= ST_ACCESS;
                ST_ACCESS: state <= ST_RESP;
                ST_RESP:   if (done) state <= ST_IDLE;   // no pop while held
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_count <= 8'd0;
            read_count  <= 8'd0;
            error_count <= 8'd0;
        end else begin
            if (b_valid && b_ready) write_count <= write_count + 8'd1;
            if (r_valid && r_ready) read_count <= read_count + 8'd1;
            if (done && rsp.resp == bus_pkg::DECERR) error_count <= error_count + 8'd1;
        end
    end

endmodule

/* hdl/bus_pkg.sv */
`include "soc_defines.svh"

package bus_pkg;

    typedef logic [`SOC_ADDR_W-1:0]   addr_t;
    typedef logic [`SOC_DATA_W-1:0]   data_t;
    typedef logic [`SOC_DATA_W/8-1:0] strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        DECERR = 2'd3   // no slave at this address
    } resp_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } rsp_t;

endpackage

/* hdl/bus_skid_buffer.sv */
`timescale 1ns/1ps

module bus_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    payload_t   slot [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);   // room left, consumer not looked at
    assign out_valid = (count != 2'd0);
    assign out_data  = slot[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            slot[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

/* hdl/led_slave.sv */
`timescale 1ns/1ps

module led_slave (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           sel,
    input  logic           we,
    input  bus_pkg::data_t wdata,
    input  bus_pkg::strb_t strb,
    output bus_pkg::data_t rdata,
    output logic [7:0]     led_value
);
    logic [7:0] led_reg;

    assign led_value = led_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led_reg <= 8'd0;
        end else if (sel && we && strb[0]) begin
            led_reg <= wdata[7:0];   // only the low byte lane
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (sel) begin
            rdata <= {{($bits(bus_pkg::data_t) - 8){1'b0}}, led_reg};
        end
    end

endmodule

/* hdl/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// on-chip memory, word-addressed by bits 9:2
`define SOC_MEM_WORDS 256

// top address nibble of each slave region
`define SOC_REGION_MEM 4'h0
`define SOC_REGION_LED 4'h2

// status pages behind the buttons
`define SOC_PAGES 4

`endif

/* hdl/soc_pkg.sv */
`include "soc_defines.svh"

package soc_pkg;

    // slave picked by the top address nibble
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_LED,
        TGT_NONE
    } target_t;

    typedef logic [$clog2(`SOC_PAGES)-1:0] page_t;

endpackage

/* hdl/soc_top.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top (
    input  logic                  sys_clk,
    input  logic                  arst_n,
    input  logic                  wr_valid,
    input  bus_pkg::addr_t        wr_addr,
    input  bus_pkg::data_t        wr_data,
    input  bus_pkg::strb_t        wr_strb,
    output logic                  wr_ready,
    output logic                  b_valid,
    output bus_pkg::resp_t        b_resp,
    input  logic                  b_ready,
    input  logic                  rd_valid,
    input  bus_pkg::addr_t        rd_addr,
    output logic                  rd_ready,
    output logic                  r_valid,
    output bus_pkg::data_t        r_data,
    output bus_pkg::resp_t        r_resp,
    input  logic                  r_ready,
    input  logic [1:0]            btn,
    output logic [7:0]            led8,
    output logic [`SOC_PAGES-1:0] led4
);
    logic             wq_valid;
    logic             wq_ready;
    bus_pkg::wr_req_t wq_data;
    logic             rq_valid;
    logic             rq_ready;
    bus_pkg::rd_req_t rq_data;
    logic             mem_sel;
    logic             led_sel;
    logic             acc_we;
    bus_pkg::addr_t   acc_addr;
    bus_pkg::data_t   acc_wdata;
    bus_pkg::strb_t   acc_strb;
    bus_pkg::data_t   mem_rdata;
    bus_pkg::data_t   led_rdata;
    logic [7:0]       led_value;
    logic [7:0]       write_count;
    logic [7:0]       read_count;
    logic [7:0]       error_count;

    bus_skid_buffer #(.payload_t(bus_pkg::wr_req_t)) u_wr_skid (
        .clk       (sys_clk),
        .arst_n    (arst_n),
        .in_valid  (wr_valid),
        .in_data   (bus_pkg::wr_req_t'{addr: wr_addr, data: wr_data, strb: wr_strb}),
        .in_ready  (wr_ready),
        .out_valid (wq_valid),
        .out_data  (wq_data),
        .out_ready (wq_ready)
    );

    bus_skid_buffer #(.payload_t(bus_pkg::rd_req_t)) u_rd_skid (
        .clk       (sys_clk),
        .arst_n    (arst_n),
        .in_valid  (rd_valid),
        .in_data   (bus_pkg::rd_req_t'{addr: rd_addr}),
        .in_ready  (rd_ready),
        .out_valid (rq_valid),
        .out_data  (rq_data),
        .out_ready (rq_ready)
    );

    bus_interconnect u_bus (
        .clk         (sys_clk),
        .arst_n      (arst_n),
        .wq_valid    (wq_valid),
        .wq_data     (wq_data),
        .wq_ready    (wq_ready),
        .rq_valid    (rq_valid),
        .rq_data     (rq_data),
        .rq_ready    (rq_ready),
        .b_valid     (b_valid),
        .b_resp      (b_resp),
        .b_ready     (b_ready),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_ready     (r_ready),
        .mem_sel     (mem_sel),
        .led_sel     (led_sel),
        .acc_we      (acc_we),
        .acc_addr    (acc_addr),
        .acc_wdata   (acc_wdata),
        .acc_strb    (acc_strb),
        .mem_rdata   (mem_rdata),
        .led_rdata   (led_rdata),
        .write_count (write_count),
        .read_count  (read_count),
        .error_count (error_count)
    );

    // memory region 0x0
    sram_slave u_sram (
        .clk   (sys_clk),
        .sel   (mem_sel),
        .we    (acc_we),
        .addr  (acc_addr),
        .wdata (acc_wdata),
        .strb  (acc_strb),
        .rdata (mem_rdata)
    );

    led_slave u_led (
        .clk       (sys_clk),
        .arst_n    (arst_n),
        .sel       (led_sel),
        .we        (acc_we),
        .wdata     (acc_wdata),
        .strb      (acc_strb),
        .rdata     (led_rdata),
        .led_value (led_value)
    );

    status_display u_display (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .btn         (btn),
        .led_value   (led_value),
        .write_count (write_count),
        .read_count  (read_count),
        .error_count (error_count),
        .led8        (led8),
        .led4        (led4)
    );

endmodule

/* hdl/sram_slave.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module sram_slave (
    input  logic           clk,
    input  logic           sel,
    input  logic           we,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    input  bus_pkg::strb_t strb,
    output bus_pkg::data_t rdata
);
    localparam int IDX_W = $clog2(`SOC_MEM_WORDS);

    bus_pkg::data_t   mem [`SOC_MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W+1:2];   // word index

    always_ff @(posedge clk) begin
        if (sel) begin
            if (we) begin
                for (int b = 0; b < $bits(bus_pkg::strb_t); b++) begin
                    if (strb[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[idx];   // old word on a write
        end
    end

endmodule

/* hdl/status_display.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module status_display (
    input  logic                  sys_clk,
    input  logic                  arst_n,
    input  logic [1:0]            btn,
    input  logic [7:0]            led_value,
    input  logic [7:0]            write_count,
    input  logic [7:0]            read_count,
    input  logic [7:0]            error_count,
    output logic [7:0]            led8,
    output logic [`SOC_PAGES-1:0] led4
);
    logic [1:0]     btn_meta;
    logic [1:0]     btn_sync;
    logic [1:0]     btn_prev;
    logic [1:0]     btn_rise;
    soc_pkg::page_t page;
    logic [7:0]     shown;

    assign btn_rise = btn_sync & ~btn_prev;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= 2'b00;
            btn_sync <= 2'b00;
            btn_prev <= 2'b00;
            page     <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            case (btn_rise)
                2'b01:   page <= page + 1'b1;   // up
                2'b10:   page <= page - 1'b1;   // down
                default: page <= page;          // both at once cancel
            endcase
        end
    end

    always_comb begin
        case (page)
            2'd0:    shown = led_value;
            2'd1:    shown = write_count;
            2'd2:    shown = read_count;
            default: shown = error_count;
        endcase
    end

    assign led8 = ~shown;   // leds are active low
    assign led4 = {{(`SOC_PAGES-1){1'b0}}, 1'b1} << page;

endmodule

/* verification/tb_soc_top.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc_top;

    // about 40 transactions of under 10 cycles plus six button presses of 8 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED           = 95036;

    logic                  sys_clk;
    logic                  arst_n;
    logic                  wr_valid;
    bus_pkg::addr_t        wr_addr;
    bus_pkg::data_t        wr_data;
    bus_pkg::strb_t        wr_strb;
    logic                  wr_ready;
    logic                  b_valid;
    bus_pkg::resp_t        b_resp;
    logic                  b_ready;
    logic                  rd_valid;
    bus_pkg::addr_t        rd_addr;
    logic                  rd_ready;
    logic                  r_valid;
    bus_pkg::data_t        r_data;
    bus_pkg::resp_t        r_resp;
    logic                  r_ready;
    logic [1:0]            btn;
    logic [7:0]            led8;
    logic [`SOC_PAGES-1:0] led4;

    bus_pkg::data_t mem_model [`SOC_MEM_WORDS];
    logic [7:0]     n_writes;   // tally of accepted responses
    logic [7:0]     n_reads;
    logic [7:0]     n_errors;
    int             page;
    int             cycles;

    soc_top uut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_resp(input string what, input bus_pkg::resp_t got,
                              input bus_pkg::resp_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s response %s, expected %s",
                     $time, what, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_data(input string what, input bus_pkg::data_t got,
                              input bus_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s data %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_leds(input logic [7:0] exp8, input logic [`SOC_PAGES-1:0] exp4);
        if (led8 !== exp8 || led4 !== exp4) begin
            $display("ERROR at %0t: led8 %h led4 %b, expected %h %b",
                     $time, led8, led4, exp8, exp4);
            stop_run();
        end
    endtask

    function automatic bus_pkg::data_t apply_strobe(input bus_pkg::data_t old_word,
                                                    input bus_pkg::data_t new_word,
                                                    input bus_pkg::strb_t strb);
        bus_pkg::data_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                              input bus_pkg::strb_t strb);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        wr_strb  = strb;
        while (!wr_ready) @(negedge sys_clk);
        @(negedge sys_clk);
        wr_valid = 1'b0;
    endtask

    task automatic wait_bresp(input bus_pkg::resp_t exp);
        while (!b_valid) @(negedge sys_clk);
        check_resp("write", b_resp, exp);
        @(negedge sys_clk);   // accepted on the rising edge in between
        n_writes = n_writes + 8'd1;
        if (exp == bus_pkg::DECERR) n_errors = n_errors + 8'd1;
    endtask

    task automatic do_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                            input bus_pkg::strb_t strb, input bus_pkg::resp_t exp);
        b_ready = 1'b1;
        send_write(addr, data, strb);
        wait_bresp(exp);
        if (exp == bus_pkg::OKAY && addr[31:28] == `SOC_REGION_MEM) begin
            mem_model[addr[9:2]] = apply_strobe(mem_model[addr[9:2]], data, strb);
        end
    endtask

    task automatic do_read(input bus_pkg::addr_t addr, input bus_pkg::data_t exp_data,
                           input bus_pkg::resp_t exp);
        r_ready  = 1'b1;
        rd_valid = 1'b1;
        rd_addr  = addr;
        while (!rd_ready) @(negedge sys_clk);
        @(negedge sys_clk);
        rd_valid = 1'b0;
        while (!r_valid) @(negedge sys_clk);
        check_resp("read", r_resp, exp);
        check_data("read", r_data, exp_data);
        @(negedge sys_clk);
        n_reads = n_reads + 8'd1;
        if (exp == bus_pkg::DECERR) n_errors = n_errors + 8'd1;
    endtask

    task automatic test_memory();
        bus_pkg::data_t data;
        bus_pkg::strb_t strb;
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            do_write(32'(i * 4), data, 4'hF, bus_pkg::OKAY);
        end
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            strb = 4'($urandom);   // partial lanes
            do_write(32'(i * 4), data, strb, bus_pkg::OKAY);
        end
        for (int i = 0; i < 8; i++) begin
            do_read(32'(i * 4), mem_model[i], bus_pkg::OKAY);
        end
    endtask

    task automatic test_led();
        do_write({`SOC_REGION_LED, 28'h0}, 32'h0000_00A5, 4'hF, bus_pkg::OKAY);
        do_read({`SOC_REGION_LED, 28'h0}, 32'h0000_00A5, bus_pkg::OKAY);
        check_leds(~8'hA5, 4'b0001);
    endtask

    task automatic test_unmapped();
        do_write({4'h1, 28'h10}, $urandom, 4'hF, bus_pkg::DECERR);
        do_write({4'h3, 28'h0}, $urandom, 4'hF, bus_pkg::DECERR);
        do_read({4'h1, 28'h10}, 32'h0, bus_pkg::DECERR);
        do_read({4'h3, 28'h4}, 32'h0, bus_pkg::DECERR);
        // same low address bits as the failed writes
        do_read(32'h0000_0010, mem_model[4], bus_pkg::OKAY);
        do_read(32'h0000_0000, mem_model[0], bus_pkg::OKAY);
        do_read({`SOC_REGION_LED, 28'h0}, 32'h0000_00A5, bus_pkg::OKAY);
        check_leds(~8'hA5, 4'b0001);
    endtask

    task automatic test_backpressure();
        bus_pkg::data_t data [3];
        bus_pkg::addr_t addr [3];
        addr[0] = 32'h40;
        addr[1] = 32'h44;
        addr[2] = 32'h40;   // overwrites the first
        b_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            data[i] = $urandom;
            send_write(addr[i], data[i], 4'hF);
        end
        while (!b_valid) @(negedge sys_clk);
        repeat (5) begin
            if (!b_valid) begin
                $display("b_valid dropped at %0t while b_ready was low", $time);
                stop_run();
            end
            check_resp("held write", b_resp, bus_pkg::OKAY);
            @(negedge sys_clk);
        end
        if (wr_ready) begin
            $display("wr_ready high at %0t with two writes queued", $time);
            stop_run();
        end
        b_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            wait_bresp(bus_pkg::OKAY);
            mem_model[addr[i][9:2]] = data[i];
        end
        do_read(32'h40, data[2], bus_pkg::OKAY);
        do_read(32'h44, data[1], bus_pkg::OKAY);
    endtask

    task automatic press_button(input int idx, input int step);
        logic [7:0] shown;
        page = (page + step + 4) % 4;
        case (page)
            0:       shown = 8'hA5;
            1:       shown = n_writes;
            2:       shown = n_reads;
            default: shown = n_errors;
        endcase
        btn[idx] = 1'b1;
        repeat (4) @(negedge sys_clk);
        check_leds(~shown, 4'(1 << page));   // within 4 cycles of the press
        btn[idx] = 1'b0;
        repeat (4) @(negedge sys_clk);
        check_leds(~shown, 4'(1 << page));   // release keeps the page
    endtask

    task automatic test_display();
        repeat (4) press_button(0, 1);   // up through all pages
        press_button(1, -1);
        press_button(1, -1);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    initial begin
        void'($urandom(SEED));
        arst_n   = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_strb  = '0;
        b_ready  = 1'b0;
        rd_valid = 1'b0;
        rd_addr  = '0;
        r_ready  = 1'b0;
        btn      = 2'b00;
        n_writes = 8'd0;
        n_reads  = 8'd0;
        n_errors = 8'd0;
        page     = 0;
        repeat (3) @(negedge sys_clk);
        arst_n = 1'b1;
        @(negedge sys_clk);
        if (!wr_ready || !rd_ready || b_valid || r_valid) begin
            $display("bus handshake not idle after reset");
            stop_run();
        end
        check_leds(8'hFF, 4'b0001);
        test_memory();
        test_led();
        test_unmapped();
        test_backpressure();
        test_display();
        $display("** PASS **");
        $finish;
    end

endmodule
